// ==== tb.f ====
hdl/soc_mem_pkg.sv
hdl/dbus_pkg.sv
hdl/dualport_mem.sv
hdl/addr_decoder.sv
hdl/periph_regs.sv
hdl/mem_subsys_top.sv
bench/mem_subsys_assert.sv
bench/tb_mem_subsys.sv

// ==== Bender.yml ====
package:
  name: mem_subsys

sources:
  # Packages first, then the design from the leaves up
  - files:
      - hdl/soc_mem_pkg.sv
      - hdl/dbus_pkg.sv
      - hdl/dualport_mem.sv
      - hdl/addr_decoder.sv
      - hdl/periph_regs.sv
      - hdl/mem_subsys_top.sv

  # Testbench and bound assertions
  - target: test
    files:
      - bench/mem_subsys_assert.sv
      - bench/tb_mem_subsys.sv

// ==== bench/tb_mem_subsys.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_mem_subsys;

    // Low words written over the data bus before anything reads them
    localparam int unsigned FILL_WORDS = 64;
    localparam int unsigned RANDOM_OPS = 200;
    // About twice the longest run of fill and random traffic
    localparam int unsigned TIMEOUT_CYCLES = 2 * (FILL_WORDS * 3 + RANDOM_OPS * 5 + 300);

    // Expected response and the cycle it belongs in
    typedef struct packed {
        logic [31:0]                        due;
        logic                               cmp_data;
        logic                               err;
        logic [soc_mem_pkg::LINE_WIDTH-1:0] data;
    } rsp_expect_s;

    logic                           clk;
    logic                           rst_n;
    soc_mem_pkg::type_icache2imem_s icache2imem;
    soc_mem_pkg::type_imem2icache_s imem2icache;
    soc_mem_pkg::type_mmu2dmem_s    mmu2dmem;
    soc_mem_pkg::type_dmem2mmu_s    dmem2mmu;
    dbus_pkg::type_dbus2peri_s      dbus_req;
    dbus_pkg::type_peri2dbus_s      dbus_rsp;

    // Reference state of memory and peripheral block
    logic [soc_mem_pkg::XLEN-1:0]   mem_model [soc_mem_pkg::MEM_WORDS];
    logic [soc_mem_pkg::XLEN-1:0]   peri_model [dbus_pkg::PERI_REGS];

    // Outstanding responses per port in arrival order
    rsp_expect_s                    fetch_q[$];
    rsp_expect_s                    mmu_q[$];
    rsp_expect_s                    dbus_q[$];

    int                             cycle = 0;
    integer                         seed;
    string                          test_name;
    logic                           traffic_done;

    mem_subsys_top u_dut (
        .clk           (clk),
        .rst_n         (rst_n),
        .icache2imem_i (icache2imem),
        .imem2icache_o (imem2icache),
        .mmu2dmem_i    (mmu2dmem),
        .dmem2mmu_o    (dmem2mmu),
        .dbus2peri_i   (dbus_req),
        .peri2dbus_o   (dbus_rsp)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic fail_with(input string msg);
        $display("%s", msg);
        $display("Simulation FAILED");
        $fatal(1, "stopped at the first error");
    endtask

    // Cycle count for due checks and the run limit
    always @(posedge clk) begin
        cycle <= cycle + 1;
        assert (cycle < TIMEOUT_CYCLES)
            else fail_with("timeout, the run did not finish within the cycle limit");
    end

    // Fill pattern mixes every address bit
    function automatic logic [31:0] fill_word(input logic [31:0] addr);
        return (addr * 32'h9E37_79B9) ^ {addr[15:0], addr[31:16]} ^ 32'h0F1E_2D3C;
    endfunction

    // Expected word or line at an address plus where the address lands
    function automatic dbus_pkg::dbus_target_e ref_read(input  logic [31:0]  addr,
                                                        output logic [31:0]  word,
                                                        output logic [127:0] line);
        logic [9:0] idx;
        idx  = addr[11:2];
        word = '0;
        // Aligned line with word 0 in the low bits
        line = {mem_model[{idx[9:2], 2'd3}], mem_model[{idx[9:2], 2'd2}],
                mem_model[{idx[9:2], 2'd1}], mem_model[{idx[9:2], 2'd0}]};
        if (addr >= soc_mem_pkg::DMEM_BASE && addr <= soc_mem_pkg::DMEM_LIMIT) begin
            word = mem_model[idx];
            return dbus_pkg::TGT_DMEM;
        end
        if (addr >= dbus_pkg::PERI_BASE &&
            addr < dbus_pkg::PERI_BASE + 32'(dbus_pkg::PERI_REGS * 4)) begin
            word = peri_model[addr[3:2]];
            return dbus_pkg::TGT_PERI;
        end
        return dbus_pkg::TGT_NONE;
    endfunction

    // Strobed merge into the model and the store counter
    function automatic void apply_write(input logic [31:0] addr, input logic [3:0] sel,
                                        input logic [31:0] data);
        dbus_pkg::dbus_target_e tgt;
        logic [31:0]            word;
        logic [127:0]           line;
        tgt = ref_read(addr, word, line);
        for (int b = 0; b < 4; b++) begin
            if (sel[b]) begin
                word[b*8 +: 8] = data[b*8 +: 8];
            end
        end
        if (tgt == dbus_pkg::TGT_DMEM) begin
            mem_model[addr[11:2]] = word;
        end else if (tgt == dbus_pkg::TGT_PERI && addr[3:2] != 2'd3) begin
            peri_model[addr[3:2]] = word;
            peri_model[3]         = peri_model[3] + 1;
        end
    endfunction

    task automatic bus_access(input logic w_en, input logic [3:0] sel,
                              input logic [31:0] addr, input logic [31:0] w_data);
        rsp_expect_s            e;
        dbus_pkg::dbus_target_e tgt;
        logic [31:0]            word;
        logic [127:0]           line;
        int                     waited;
        @(posedge clk);
        #1;
        tgt = ref_read(addr, word, line);
        // Stores and error responses land in the same cycle and loads one later
        e.due      = (w_en || tgt == dbus_pkg::TGT_NONE) ? cycle : cycle + 1;
        e.err      = (tgt == dbus_pkg::TGT_NONE);
        e.cmp_data = !w_en || tgt == dbus_pkg::TGT_NONE;
        e.data     = {96'h0, (w_en ? 32'h0 : word)};
        dbus_q.push_back(e);
        dbus_req = '{cyc: 1'b1, w_en: w_en, sel_byte: sel, addr: addr, w_data: w_data};
        waited   = 0;
        @(negedge clk);
        while (!dbus_rsp.ack) begin
            waited++;
            assert (waited < 4) else fail_with("data-bus access was never acknowledged");
            @(negedge clk);
        end
        // Commit edge is still ahead so fetch and MMU see the old word until then
        if (w_en && tgt != dbus_pkg::TGT_NONE) begin
            apply_write(addr, sel, w_data);
        end
        @(posedge clk);
        #1;
        dbus_req.cyc = 1'b0;
    endtask

    task automatic fetch_pulse(input logic [31:0] addr);
        rsp_expect_s e;
        logic [31:0]  word;
        logic [127:0] line;
        @(posedge clk);
        #1;
        // Only the memory region answers
        if (ref_read(addr, word, line) == dbus_pkg::TGT_DMEM) begin
            e = '{due: cycle + 1, cmp_data: 1'b1, err: 1'b0, data: line};
            fetch_q.push_back(e);
        end
        icache2imem = '{req: 1'b1, addr: addr};
        @(posedge clk);
        #1;
        icache2imem.req = 1'b0;
    endtask

    // Held request gets a response on every second cycle
    task automatic mmu_read(input logic [31:0] paddr, input int hold_cycles);
        rsp_expect_s e;
        logic [31:0]  word;
        logic [127:0] line;
        @(posedge clk);
        #1;
        // Upper address bits play no part since the index wraps
        void'(ref_read({20'h0, paddr[11:0]}, word, line));
        e = '{due: 0, cmp_data: 1'b1, err: 1'b0, data: {96'h0, word}};
        for (int k = 1; k <= hold_cycles; k += 2) begin
            e.due = cycle + k;
            mmu_q.push_back(e);
        end
        mmu2dmem = '{r_req: 1'b1, paddr: paddr};
        repeat (hold_cycles) @(posedge clk);
        #1;
        mmu2dmem.r_req = 1'b0;
    endtask

    task automatic random_bus_op();
        logic [31:0] r;
        logic [31:0] addr;
        logic [3:0]  sel;
        r = $random(seed);
        case (r[1:0])
            2'd2:    addr = dbus_pkg::PERI_BASE + {r[5:4], 2'b00};
            2'd3:    addr = 32'h0002_0000 | {r[11:2], 2'b00};
            default: addr = {24'h0, r[11:6], 2'b00};
        endcase
        sel = (r[15:12] == 4'h0) ? 4'hF : r[15:12];
        bus_access(r[16], sel, addr, $random(seed));
    endtask

    task automatic compare_rsp(input string port, input rsp_expect_s e,
                               input logic [127:0] act, input logic act_err);
        assert (e.due == cycle)
            else fail_with($sformatf("%s %s response came in cycle %0d instead of %0d",
                                     test_name, port, cycle, e.due));
        assert (act_err === e.err)
            else fail_with($sformatf("mismatch %s %s err expected %0b actual %0b",
                                     test_name, port, e.err, act_err));
        if (e.cmp_data) begin
            assert (act === e.data)
                else fail_with($sformatf("mismatch %s %s expected %h actual %h",
                                         test_name, port, e.data, act));
        end
    endtask

    // Mid-cycle compare of every response port
    always @(negedge clk) begin
        if (rst_n) begin
            assert (u_dut.u_assert.assert_fails == 0)
                else fail_with("a bound protocol assertion failed");
            if (imem2icache.ack) begin
                assert (fetch_q.size() > 0) else fail_with("fetch ack without a request");
                compare_rsp("fetch", fetch_q.pop_front(), imem2icache.data, 1'b0);
            end
            if (dmem2mmu.r_valid) begin
                assert (mmu_q.size() > 0) else fail_with("mmu r_valid without a request");
                compare_rsp("mmu", mmu_q.pop_front(), {96'h0, dmem2mmu.r_data}, 1'b0);
            end
            if (dbus_rsp.ack) begin
                assert (dbus_q.size() > 0) else fail_with("data-bus ack without a request");
                compare_rsp("dbus", dbus_q.pop_front(), {96'h0, dbus_rsp.r_data},
                            dbus_rsp.err);
            end
            // Overdue entries were never answered
            assert (fetch_q.size() == 0 || fetch_q[0].due > cycle)
                else fail_with("fetch request got no ack");
            assert (mmu_q.size() == 0 || mmu_q[0].due > cycle)
                else fail_with("mmu request got no r_valid");
            assert (dbus_q.size() == 0 || dbus_q[0].due > cycle)
                else fail_with("data-bus request got no ack");
        end
    end

    initial begin
        seed         = 42;
        rst_n        = 1'b0;
        icache2imem  = '0;
        mmu2dmem     = '0;
        dbus_req     = '0;
        traffic_done = 1'b0;
        test_name    = "reset";
        for (int r = 0; r < dbus_pkg::PERI_REGS; r++) begin
            peri_model[r] = '0;
        end
        repeat (4) @(posedge clk);
        #1;
        rst_n = 1'b1;

        test_name = "fill";
        for (int w = 0; w < FILL_WORDS; w++) begin
            bus_access(1'b1, 4'hF, 32'(w * 4), fill_word(32'(w * 4)));
        end

        test_name = "byte_store";
        bus_access(1'b1, 4'hF, 32'h40, 32'hDEAD_BEEF);
        bus_access(1'b0, 4'h0, 32'h40, 32'h0);
        for (int b = 0; b < 4; b++) begin
            bus_access(1'b1, 4'(1 << b), 32'h44, $random(seed));
            bus_access(1'b0, 4'h0, 32'h44, 32'h0);
        end

        test_name = "fetch";
        for (int k = 0; k < 8; k++) begin
            fetch_pulse($random(seed) & 32'h0000_00FF);
        end
        // No ack may follow within the next cycles
        fetch_pulse(32'h0000_2004);
        repeat (4) @(posedge clk);

        test_name = "mmu";
        for (int k = 0; k < 8; k++) begin
            mmu_read($random(seed) & 32'hFFFF_F0FC, 1);
        end
        mmu_read(32'h0000_0084, 6);

        test_name = "peri";
        for (int r = 0; r < 3; r++) begin
            bus_access(1'b1, 4'hF, dbus_pkg::PERI_BASE + 32'(r * 4), $random(seed));
            bus_access(1'b1, 4'b0100, dbus_pkg::PERI_BASE + 32'(r * 4), $random(seed));
            bus_access(1'b0, 4'h0, dbus_pkg::PERI_BASE + 32'(r * 4), 32'h0);
        end
        // Counter read and an ignored write to it
        bus_access(1'b0, 4'h0, dbus_pkg::PERI_BASE + 32'hC, 32'h0);
        bus_access(1'b1, 4'hF, dbus_pkg::PERI_BASE + 32'hC, 32'hFFFF_FFFF);
        bus_access(1'b0, 4'h0, dbus_pkg::PERI_BASE + 32'hC, 32'h0);

        test_name = "unmapped";
        bus_access(1'b1, 4'hF, 32'h0002_0000, 32'h1234_5678);
        bus_access(1'b0, 4'h0, 32'h0001_0010, 32'h0);
        bus_access(1'b0, 4'h0, 32'h8000_0000, 32'h0);

        // Data bus plus background walker and fetch traffic
        test_name = "random";
        fork
            begin
                for (int n = 0; n < RANDOM_OPS; n++) begin
                    random_bus_op();
                end
                traffic_done = 1'b1;
            end
            while (!traffic_done) begin
                mmu_read($random(seed) & 32'hFFFF_F0FC, 1);
            end
            while (!traffic_done) begin
                fetch_pulse($random(seed) & 32'h0000_10FF);
            end
        join

        repeat (3) @(posedge clk);
        if (fetch_q.size() == 0 && mmu_q.size() == 0 && dbus_q.size() == 0) begin
            $display("Simulation PASSED");
            $finish;
        end else begin
            fail_with("responses still outstanding at the end of the run");
        end
    end

endmodule : tb_mem_subsys

`default_nettype wire

// ==== bench/mem_subsys_assert.sv ====
`timescale 1ns/1ps
`default_nettype none

module mem_subsys_assert (
    input wire                                 clk,
    input wire                                 rst_n,
    input wire soc_mem_pkg::type_icache2imem_s icache_req_i,
    input wire soc_mem_pkg::type_imem2icache_s icache_rsp_i,
    input wire soc_mem_pkg::type_dmem2mmu_s    mmu_rsp_i,
    input wire dbus_pkg::type_dbus2peri_s      dbus_req_i,
    input wire dbus_pkg::type_peri2dbus_s      dbus_rsp_i
);

    // Number of failed protocol checks
    int unsigned assert_fails = 0;

    // No target answers an idle bus
    ack_needs_cyc: assert property (@(posedge clk) disable iff (!rst_n)
        dbus_rsp_i.ack |-> dbus_req_i.cyc)
        else begin
            $error("data-bus ack seen without cyc");
            assert_fails++;
        end

    // Walker responses always leave a gap
    mmu_gap: assert property (@(posedge clk) disable iff (!rst_n)
        mmu_rsp_i.r_valid |=> !mmu_rsp_i.r_valid)
        else begin
            $error("mmu r_valid high on two cycles in a row");
            assert_fails++;
        end

    err_with_ack: assert property (@(posedge clk) disable iff (!rst_n)
        dbus_rsp_i.err |-> dbus_rsp_i.ack)
        else begin
            $error("data-bus err without ack");
            assert_fails++;
        end

    // Line ack only after an in-region request
    fetch_in_region: assert property (@(posedge clk) disable iff (!rst_n)
        icache_rsp_i.ack |-> $past(icache_req_i.req &&
                                   icache_req_i.addr >= soc_mem_pkg::DMEM_BASE &&
                                   icache_req_i.addr <= soc_mem_pkg::DMEM_LIMIT))
        else begin
            $error("fetch ack without an in-region request");
            assert_fails++;
        end

endmodule : mem_subsys_assert

bind mem_subsys_top mem_subsys_assert u_assert (
    .clk          (clk),
    .rst_n        (rst_n),
    .icache_req_i (icache2imem_i),
    .icache_rsp_i (imem2icache_o),
    .mmu_rsp_i    (dmem2mmu_o),
    .dbus_req_i   (dbus2peri_i),
    .dbus_rsp_i   (peri2dbus_o)
);

`default_nettype wire

// ==== hdl/mem_subsys_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module mem_subsys_top (
    input  wire                                 clk,
    input  wire                                 rst_n,

    // Instruction cache refill
    input  wire soc_mem_pkg::type_icache2imem_s icache2imem_i,
    output soc_mem_pkg::type_imem2icache_s      imem2icache_o,

    // Page-table walker
    input  wire soc_mem_pkg::type_mmu2dmem_s    mmu2dmem_i,
    output soc_mem_pkg::type_dmem2mmu_s         dmem2mmu_o,

    // Data bus
    input  wire dbus_pkg::type_dbus2peri_s      dbus2peri_i,
    output dbus_pkg::type_peri2dbus_s           peri2dbus_o
);

    // Decoder selects
    logic imem_sel;
    logic dmem_sel;
    logic peri_sel;

    // Per-target responses before the mux
    dbus_pkg::type_peri2dbus_s dmem_rsp;
    dbus_pkg::type_peri2dbus_s peri_rsp;

    addr_decoder u_decoder (
        .icache_addr_i (icache2imem_i.addr),
        .dbus2dec_i    (dbus2peri_i),
        .dmem_rsp_i    (dmem_rsp),
        .peri_rsp_i    (peri_rsp),
        .imem_sel_o    (imem_sel),
        .dmem_sel_o    (dmem_sel),
        .peri_sel_o    (peri_sel),
        .dbus_rsp_o    (peri2dbus_o)
    );

    // Request struct fans out to both targets
    dualport_mem u_mem (
        .clk           (clk),
        .rst_n         (rst_n),
        .icache2imem_i (icache2imem_i),
        .imem2icache_o (imem2icache_o),
        .mmu2dmem_i    (mmu2dmem_i),
        .dmem2mmu_o    (dmem2mmu_o),
        .dbus2dmem_i   (dbus2peri_i),
        .dmem2dbus_o   (dmem_rsp),
        .imem_sel_i    (imem_sel),
        .dmem_sel_i    (dmem_sel)
    );

    periph_regs u_peri (
        .clk         (clk),
        .rst_n       (rst_n),
        .dbus2peri_i (dbus2peri_i),
        .peri_sel_i  (peri_sel),
        .peri2dbus_o (peri_rsp)
    );

endmodule : mem_subsys_top

`default_nettype wire

// ==== hdl/periph_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

module periph_regs (
    input  wire                             clk,
    input  wire                             rst_n,
    input  wire dbus_pkg::type_dbus2peri_s  dbus2peri_i,
    input  wire                             peri_sel_i,
    output dbus_pkg::type_peri2dbus_s       peri2dbus_o
);

    // Top entry is the store counter, the rest are scratch
    logic [soc_mem_pkg::XLEN-1:0]           regs_q [dbus_pkg::PERI_REGS];
    logic [$clog2(dbus_pkg::PERI_REGS)-1:0] reg_idx;
    logic                                   bus_wr;
    logic                                   bus_rd;
    logic                                   scratch_wr;
    logic                                   rd_ack_q;
    logic [soc_mem_pkg::XLEN-1:0]           rdata_q;

    assign reg_idx    = dbus2peri_i.addr[$clog2(dbus_pkg::PERI_REGS)+1:2];
    assign bus_wr     = peri_sel_i & dbus2peri_i.w_en;
    assign bus_rd     = peri_sel_i & ~dbus2peri_i.w_en;
    // Counter register takes the ack but no data
    assign scratch_wr = bus_wr && (reg_idx < dbus_pkg::PERI_REGS - 1);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int r = 0; r < dbus_pkg::PERI_REGS; r++) begin
                regs_q[r] <= '0;
            end
        end else if (scratch_wr) begin
            for (int b = 0; b < soc_mem_pkg::XLEN / 8; b++) begin
                if (dbus2peri_i.sel_byte[b]) begin
                    regs_q[reg_idx][b*8 +: 8] <= dbus2peri_i.w_data[b*8 +: 8];
                end
            end
            // Count every accepted scratch write
            regs_q[dbus_pkg::PERI_REGS-1] <= regs_q[dbus_pkg::PERI_REGS-1] + 1'b1;
        end
    end

    // Same load timing as the memory port
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rd_ack_q <= 1'b0;
        end else begin
            rd_ack_q <= bus_rd & ~rd_ack_q;
        end
    end

    always_ff @(posedge clk) begin
        if (bus_rd & ~rd_ack_q) begin
            rdata_q <= regs_q[reg_idx];
        end
    end

    // Zero response unless selected
    always_comb begin
        peri2dbus_o     = '0;
        peri2dbus_o.ack = bus_wr | (bus_rd & rd_ack_q);
        if (bus_rd & rd_ack_q) begin
            peri2dbus_o.r_data = rdata_q;
        end
    end

endmodule : periph_regs

`default_nettype wire

// ==== hdl/addr_decoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module addr_decoder (
    // Fetch address from the instruction cache
    input  wire [soc_mem_pkg::XLEN-1:0]     icache_addr_i,

    // Data-bus request as seen by all targets
    input  wire dbus_pkg::type_dbus2peri_s  dbus2dec_i,

    // Target responses, zero when not selected
    input  wire dbus_pkg::type_peri2dbus_s  dmem_rsp_i,
    input  wire dbus_pkg::type_peri2dbus_s  peri_rsp_i,

    // Target selects
    output logic                            imem_sel_o,
    output logic                            dmem_sel_o,
    output logic                            peri_sel_o,

    // Merged response to the master
    output dbus_pkg::type_peri2dbus_s       dbus_rsp_o
);

    dbus_pkg::dbus_target_e target;

    logic in_dmem;
    logic in_peri;

    // Fetch only allowed inside the memory region
    assign imem_sel_o = (icache_addr_i >= soc_mem_pkg::DMEM_BASE) &&
                        (icache_addr_i <= soc_mem_pkg::DMEM_LIMIT);

    // Region hits for the data bus
    assign in_dmem = (dbus2dec_i.addr >= soc_mem_pkg::DMEM_BASE) &&
                     (dbus2dec_i.addr <= soc_mem_pkg::DMEM_LIMIT);
    assign in_peri = (dbus2dec_i.addr >= dbus_pkg::PERI_BASE) &&
                     (dbus2dec_i.addr < dbus_pkg::PERI_BASE + 32'(dbus_pkg::PERI_REGS * 4));

    // Idle bus decodes to no target
    always_comb begin
        if (!dbus2dec_i.cyc) begin
            target = dbus_pkg::TGT_NONE;
        end else if (in_dmem) begin
            target = dbus_pkg::TGT_DMEM;
        end else if (in_peri) begin
            target = dbus_pkg::TGT_PERI;
        end else begin
            target = dbus_pkg::TGT_NONE;
        end
    end

    assign dmem_sel_o = (target == dbus_pkg::TGT_DMEM);
    assign peri_sel_o = (target == dbus_pkg::TGT_PERI);

    // Response mux
    always_comb begin
        dbus_rsp_o = '0;
        case (target)
            dbus_pkg::TGT_DMEM: begin
                dbus_rsp_o = dmem_rsp_i;
            end
            dbus_pkg::TGT_PERI: begin
                dbus_rsp_o = peri_rsp_i;
            end
            default: begin
                // Unmapped access, error ack in the same cycle
                dbus_rsp_o.ack = dbus2dec_i.cyc;
                dbus_rsp_o.err = dbus2dec_i.cyc;
            end
        endcase
    end

endmodule : addr_decoder

`default_nettype wire

// ==== hdl/dualport_mem.sv ====
`timescale 1ns/1ps
`default_nettype none

module dualport_mem (
    input  wire                             clk,
    input  wire                             rst_n,

    // Instruction cache refill
    input  wire soc_mem_pkg::type_icache2imem_s icache2imem_i,
    output soc_mem_pkg::type_imem2icache_s      imem2icache_o,

    // Page-table walk reads
    input  wire soc_mem_pkg::type_mmu2dmem_s    mmu2dmem_i,
    output soc_mem_pkg::type_dmem2mmu_s         dmem2mmu_o,

    // Data-bus loads and stores
    input  wire dbus_pkg::type_dbus2peri_s      dbus2dmem_i,
    output dbus_pkg::type_peri2dbus_s           dmem2dbus_o,

    // Region qualifiers from the decoder
    input  wire                             imem_sel_i,
    input  wire                             dmem_sel_i
);

    // Shared word array, no reset on contents
    logic [soc_mem_pkg::XLEN-1:0] mem_q [soc_mem_pkg::MEM_WORDS];

    // Fetch side
    logic                                    fetch_req;
    logic [soc_mem_pkg::MEM_ADDR_WIDTH-3:0]  line_idx;
    logic                                    fetch_ack_q;
    logic [soc_mem_pkg::LINE_WIDTH-1:0]      fetch_line_q;

    // MMU side
    logic [soc_mem_pkg::MEM_ADDR_WIDTH-1:0]  mmu_idx;
    logic                                    mmu_valid_q;
    logic [soc_mem_pkg::XLEN-1:0]            mmu_data_q;

    // Data-bus side
    logic [soc_mem_pkg::MEM_ADDR_WIDTH-1:0]  dbus_idx;
    logic                                    dbus_wr;
    logic                                    dbus_rd;
    logic                                    dbus_rd_ack_q;
    logic [soc_mem_pkg::XLEN-1:0]            dbus_rdata_q;

    // Fetch qualified by region, line index drops the low four bits
    assign fetch_req = icache2imem_i.req & imem_sel_i;
    assign line_idx  = icache2imem_i.addr[soc_mem_pkg::MEM_ADDR_WIDTH+1:4];

    // Word index, upper bits ignored so the walker wraps
    assign mmu_idx  = mmu2dmem_i.paddr[soc_mem_pkg::MEM_ADDR_WIDTH+1:2];
    assign dbus_idx = dbus2dmem_i.addr[soc_mem_pkg::MEM_ADDR_WIDTH+1:2];

    // Select already carries cyc from the decoder
    assign dbus_wr = dmem_sel_i & dbus2dmem_i.w_en;
    assign dbus_rd = dmem_sel_i & ~dbus2dmem_i.w_en;

    // Store commits on the edge closing the acked cycle
    always_ff @(posedge clk) begin
        if (dbus_wr) begin
            for (int b = 0; b < soc_mem_pkg::XLEN / 8; b++) begin
                if (dbus2dmem_i.sel_byte[b]) begin
                    mem_q[dbus_idx][b*8 +: 8] <= dbus2dmem_i.w_data[b*8 +: 8];
                end
            end
        end
    end

    // Line ack, one per sampled request
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            fetch_ack_q <= 1'b0;
        end else begin
            fetch_ack_q <= fetch_req;
        end
    end

    // Four consecutive words, word 0 in the low bits
    always_ff @(posedge clk) begin
        if (fetch_req) begin
            for (int k = 0; k < soc_mem_pkg::LINE_WIDTH / soc_mem_pkg::XLEN; k++) begin
                fetch_line_q[k*soc_mem_pkg::XLEN +: soc_mem_pkg::XLEN] <=
                    mem_q[{line_idx, 2'(k)}];
            end
        end
    end

    assign imem2icache_o.ack  = fetch_ack_q;
    assign imem2icache_o.data = fetch_line_q;

    // Walker response, gap cycle after each valid
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            mmu_valid_q <= 1'b0;
        end else begin
            mmu_valid_q <= mmu2dmem_i.r_req & ~mmu_valid_q;
        end
    end

    always_ff @(posedge clk) begin
        if (mmu2dmem_i.r_req & ~mmu_valid_q) begin
            mmu_data_q <= mem_q[mmu_idx];
        end
    end

    assign dmem2mmu_o.r_valid = mmu_valid_q;
    assign dmem2mmu_o.r_data  = mmu_data_q;

    // Load ack one edge after cyc, then held low for a cycle
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            dbus_rd_ack_q <= 1'b0;
        end else begin
            dbus_rd_ack_q <= dbus_rd & ~dbus_rd_ack_q;
        end
    end

    // Old word returned on a same-word store
    always_ff @(posedge clk) begin
        if (dbus_rd & ~dbus_rd_ack_q) begin
            dbus_rdata_q <= mem_q[dbus_idx];
        end
    end

    // Store ack is immediate, response is zero when unselected
    always_comb begin
        dmem2dbus_o        = '0;
        dmem2dbus_o.ack    = dbus_wr | (dbus_rd & dbus_rd_ack_q);
        if (dbus_rd & dbus_rd_ack_q) begin
            dmem2dbus_o.r_data = dbus_rdata_q;
        end
    end

endmodule : dualport_mem

`default_nettype wire

// ==== hdl/dbus_pkg.sv ====
`default_nettype none

// Data-bus request and response types plus the decode result
package dbus_pkg;

    // Peripheral block base, 16 bytes long
    localparam logic [soc_mem_pkg::XLEN-1:0] PERI_BASE = 32'h0001_0000;

    // Three scratch registers and one store counter
    localparam int unsigned PERI_REGS = 4;

    // Request from the data-bus master
    typedef struct packed {
        logic                            cyc;
        logic                            w_en;
        logic [soc_mem_pkg::XLEN/8-1:0]  sel_byte;
        logic [soc_mem_pkg::XLEN-1:0]    addr;
        logic [soc_mem_pkg::XLEN-1:0]    w_data;
    } type_dbus2peri_s;

    // Response from a data-bus target
    typedef struct packed {
        logic                         ack;
        logic                         err;
        logic [soc_mem_pkg::XLEN-1:0] r_data;
    } type_peri2dbus_s;

    // Where a data-bus address lands
    typedef enum logic [1:0] {
        TGT_DMEM = 2'd0,
        TGT_PERI = 2'd1,
        TGT_NONE = 2'd2
    } dbus_target_e;

endpackage : dbus_pkg

`default_nettype wire

// ==== hdl/soc_mem_pkg.sv ====
`default_nettype none

// Memory geometry, address map and the fetch and MMU port types
package soc_mem_pkg;

    // Data word width
    localparam int unsigned XLEN = 32;

    // Memory depth in words, 4 KB total
    localparam int unsigned MEM_WORDS = 1024;

    // Word index width into the array
    localparam int unsigned MEM_ADDR_WIDTH = 10;

    // One cache line holds four words
    localparam int unsigned LINE_WIDTH = 128;

    // Memory region, shared by fetch and data bus
    localparam logic [XLEN-1:0] DMEM_BASE  = 32'h0000_0000;
    localparam logic [XLEN-1:0] DMEM_LIMIT = 32'h0000_0FFF;

    // Fetch request from the instruction cache
    typedef struct packed {
        logic            req;
        logic [XLEN-1:0] addr;
    } type_icache2imem_s;

    // Line response back to the instruction cache
    typedef struct packed {
        logic                  ack;
        logic [LINE_WIDTH-1:0] data;
    } type_imem2icache_s;

    // Page-table walk read request
    typedef struct packed {
        logic            r_req;
        logic [XLEN-1:0] paddr;
    } type_mmu2dmem_s;

    // Single-word response to the walker
    typedef struct packed {
        logic            r_valid;
        logic [XLEN-1:0] r_data;
    } type_dmem2mmu_s;

endpackage : soc_mem_pkg

`default_nettype wire
